// ==== csr_unit.f ====
+incdir+.
csr_pkg.sv
csr_counters.sv
csr_machine.sv
csr_unit.sv
csr_checker.sv
tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - csr_pkg.sv
  - csr_counters.sv
  - csr_machine.sv
  - csr_unit.sv
  - target: test
    files:
      - csr_checker.sv
      - tb_csr_unit.sv

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ps

`include "csr_defines.svh"

module tb_csr_unit;

    typedef struct packed
    {
        logic        wr;
        logic        set;
        logic        clr;
        logic        rd;
        logic        masked;
        logic        ebreak;
        logic        issue;
        logic        imm_sel;
        logic [11:0] idx;
        logic [31:0] data;
        logic [4:0]  imm;
        logic [31:0] pc;
        logic [1:0]  kind; // 0 none, 1 value, 2 model, 3 issue count
        logic [31:0] exp;
    } entry_t;

    logic        clk;
    logic        reset;
    logic [31:0] reg_data;
    logic [11:0] idx;
    logic [4:0]  imm;
    logic        imm_sel, wr, set, clr, rd, masked, ebreak, issued;
    logic [31:1] pc_next;
    logic [1:0]  exp_kind;
    logic [31:0] exp_value;
    logic [31:0] data;
    logic        rd_strobe, csr_to_trap;
    logic [31:1] trap_pc, ret_addr;
    int          errors, checks;

    entry_t      table_q[$];
    int          issue_total;
    int          cycle_count;

    csr_unit UUT
    (
        .i_clk(clk), .i_reset(reset), .i_reg_data(reg_data), .i_idx(idx), .i_imm(imm),
        .i_imm_sel(imm_sel), .i_write(wr), .i_set(set), .i_clear(clr), .i_read(rd),
        .i_masked(masked), .i_ebreak(ebreak), .i_instr_issued(issued), .i_pc_next(pc_next),
        .o_data(data), .o_read(rd_strobe), .o_csr_to_trap(csr_to_trap),
        .o_trap_pc(trap_pc), .o_ret_addr(ret_addr)
    );

    csr_checker u_checker
    (
        .i_clk(clk), .i_reset(reset), .i_reg_data(reg_data), .i_idx(idx), .i_imm(imm),
        .i_imm_sel(imm_sel), .i_write(wr), .i_set(set), .i_clear(clr), .i_read(rd),
        .i_masked(masked), .i_ebreak(ebreak), .i_instr_issued(issued), .i_pc_next(pc_next),
        .i_exp_kind(exp_kind), .i_exp_value(exp_value), .i_data(data),
        .i_rd_strobe(rd_strobe), .i_csr_to_trap(csr_to_trap), .i_trap_pc(trap_pc),
        .i_ret_addr(ret_addr), .o_errors(errors), .o_checks(checks)
    );

    always #4 clk = ~clk;

    // ops given as "w", "s", "c" or "-"
    task automatic add_entry(input string op, input logic r, input logic m, input logic eb,
                             input logic iss, input logic isel, input logic [11:0] ix,
                             input logic [31:0] d, input logic [4:0] im, input logic [31:0] p,
                             input logic [1:0] k, input logic [31:0] e);
        entry_t en;
        en = '0;
        en.wr = (op == "w");
        en.set = (op == "s");
        en.clr = (op == "c");
        en.rd = r;
        en.masked = m;
        en.ebreak = eb;
        en.issue = iss;
        en.imm_sel = isel;
        en.idx = ix;
        en.data = d;
        en.imm = im;
        en.pc = p;
        en.kind = k;
        if (iss)
            issue_total = issue_total + 1;
        en.exp = (k == 2'd3) ? issue_total : e; // counted on the strobe edge
        table_q.push_back(en);
    endtask

    task automatic drive_entry(input entry_t en);
        wr = en.wr;
        set = en.set;
        clr = en.clr;
        rd = en.rd;
        masked = en.masked;
        ebreak = en.ebreak;
        issued = en.issue;
        imm_sel = en.imm_sel;
        idx = en.idx;
        reg_data = en.data;
        imm = en.imm;
        pc_next = en.pc[31:1];
        exp_kind = en.kind;
        exp_value = en.exp;
    endtask

    task automatic build_table();
        add_entry("w", 0, 0, 0, 1, 0, `CSR_IDX_MSCRATCH, 32'h1234_5678, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 1, 0, `CSR_IDX_MSCRATCH, 0, 0, 0, 1, 32'h1234_5678);
        add_entry("s", 0, 0, 0, 0, 1, `CSR_IDX_MSCRATCH, 0, 5'h1f, 0, 0, 0);
        add_entry("-", 1, 0, 0, 1, 0, `CSR_IDX_MSCRATCH, 0, 0, 0, 1, 32'h1234_567F);
        add_entry("c", 0, 0, 0, 0, 0, `CSR_IDX_MSCRATCH, 32'h0000_00F0, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MSCRATCH, 0, 0, 0, 1, 32'h1234_560F);
        add_entry("c", 0, 0, 0, 1, 1, `CSR_IDX_MSCRATCH, 0, 5'h0f, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MSCRATCH, 0, 0, 0, 1, 32'h1234_5600);
        add_entry("w", 0, 0, 0, 0, 0, `CSR_IDX_MTVEC, 32'h8000_0101, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 1, 0, `CSR_IDX_MTVEC, 0, 0, 0, 1, 32'h8000_0100);
        add_entry("s", 0, 0, 0, 0, 1, `CSR_IDX_MTVEC, 0, 5'h06, 0, 0, 0);
        add_entry("c", 0, 0, 0, 0, 0, `CSR_IDX_MTVEC, 32'h0000_0100, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MTVEC, 0, 0, 0, 1, 32'h8000_0006);
        // masked strobe with a read
        add_entry("w", 1, 1, 0, 0, 0, `CSR_IDX_MSCRATCH, 32'hDEAD_BEEF, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MSCRATCH, 0, 0, 0, 1, 32'h1234_5600);
        add_entry("-", 1, 0, 0, 0, 0, 12'h100, 0, 0, 0, 1, 0);
        add_entry("w", 0, 0, 0, 0, 0, 12'h105, 32'hFFFF_FFFF, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, 12'h105, 0, 0, 0, 1, 0);
        add_entry("-", 1, 0, 0, 0, 0, 12'h200, 0, 0, 0, 1, 0);
        add_entry("-", 1, 0, 0, 0, 0, 12'h3C0, 0, 0, 0, 1, 0);
        add_entry("w", 0, 0, 0, 0, 0, `CSR_IDX_MISA, 32'h0, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MISA, 0, 0, 0, 1, `CSR_MISA_VALUE);
        add_entry("w", 0, 0, 0, 1, 0, `CSR_IDX_CYCLE, 32'h0000_FFFF, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_CYCLE, 0, 0, 0, 2, 0);
        add_entry("-", 1, 0, 0, 1, 0, `CSR_IDX_INSTRET, 0, 0, 0, 3, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_CYCLEH, 0, 0, 0, 1, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_INSTRETH, 0, 0, 0, 1, 0);
        // trap entry with mie set beforehand
        add_entry("s", 0, 0, 0, 0, 0, `CSR_IDX_MSTATUS, 32'hFFFF_FFFF, 0, 0, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MSTATUS, 0, 0, 0, 1, 32'h0000_0088);
        add_entry("c", 0, 0, 0, 0, 0, `CSR_IDX_MSTATUS, 32'h0000_0088, 0, 0, 0, 0);
        add_entry("s", 0, 0, 0, 0, 1, `CSR_IDX_MSTATUS, 0, 5'h08, 0, 0, 0);
        add_entry("-", 0, 0, 1, 0, 0, 12'h000, 0, 0, 32'h0000_2468, 0, 0);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MEPC, 0, 0, 0, 1, 32'h0000_2468);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MCAUSE, 0, 0, 0, 1, `CSR_CAUSE_BREAKPOINT);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MSTATUS, 0, 0, 0, 1, 32'h0000_0080);
        // trap beats a write to mepc
        add_entry("w", 0, 0, 1, 0, 0, `CSR_IDX_MEPC, 32'h0000_0100, 0, 32'h0000_3000, 0, 0);
        add_entry("-", 1, 0, 0, 1, 0, `CSR_IDX_MEPC, 0, 0, 0, 1, 32'h0000_3000);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MSTATUS, 0, 0, 0, 1, 32'h0000_0000);
        add_entry("w", 1, 0, 0, 0, 0, `CSR_IDX_MSCRATCH, 32'hA5A5_A5A5, 0, 0, 1, 32'h1234_5600);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_MSCRATCH, 0, 0, 0, 1, 32'hA5A5_A5A5);
        add_entry("-", 1, 0, 0, 0, 0, `CSR_IDX_INSTRET, 0, 0, 0, 3, 0);
    endtask

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= 2 * table_q.size() + 40)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        cycle_count = 0;
        issue_total = 0;
        drive_entry('0);
        build_table();
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        foreach (table_q[i])
        begin
            @(posedge clk);
            #1 drive_entry(table_q[i]);
            @(posedge clk);
            #1 drive_entry('0); // idle cycle
        end
        repeat (3) @(posedge clk);
        #2;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== csr_checker.sv ====
`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_checker
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic [31:0]                 i_reg_data,
    input  logic [11:0]                 i_idx,
    input  logic [4:0]                  i_imm,
    input  logic                        i_imm_sel,
    input  logic                        i_write,
    input  logic                        i_set,
    input  logic                        i_clear,
    input  logic                        i_read,
    input  logic                        i_masked,
    input  logic                        i_ebreak,
    input  logic                        i_instr_issued,
    input  logic [`CSR_IADDR_BITS-1:1]  i_pc_next,
    input  logic [1:0]                  i_exp_kind,
    input  logic [31:0]                 i_exp_value,
    input  logic [31:0]                 i_data,
    input  logic                        i_rd_strobe,
    input  logic                        i_csr_to_trap,
    input  logic [`CSR_IADDR_BITS-1:1]  i_trap_pc,
    input  logic [`CSR_IADDR_BITS-1:1]  i_ret_addr,
    output int                          o_errors,
    output int                          o_checks
);

    // expectation kind is 0 none, 1 table value, 2 model only or 3 issue count
    logic [31:0] mstatus, mtvec, mscratch, mepc, mcause;
    logic [63:0] cyc, inst;

    // request seen one edge ago
    logic [1:0]  p_op;
    logic [11:0] p_idx;
    logic [31:0] p_wdata;
    logic        p_read;
    logic        p_ebreak;
    logic [31:0] p_pc;
    logic [1:0]  p_kind;
    logic [31:0] p_exp;

    function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] old_v,
                                             input logic [31:0] wd);
        logic [31:0] r;
        r = old_v;
        if (op == 2'd1)
            r = wd;
        else if (op == 2'd2)
            r = old_v | wd;
        else if (op == 2'd3)
            r = old_v & ~wd;
        return r;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] idx);
        logic [31:0] r;
        r = '0;
        if (idx[9:8] == 2'b00)
        begin
            if (idx[7:0] == 8'h00)
                r = cyc[31:0];
            else if (idx[7:0] == 8'h02)
                r = inst[31:0];
            else if (idx[7:0] == 8'h80)
                r = cyc[63:32];
            else if (idx[7:0] == 8'h82)
                r = inst[63:32];
        end
        else if (idx[9:8] == 2'b11)
        begin
            if (idx == `CSR_IDX_MSTATUS)
                r = mstatus;
            else if (idx == `CSR_IDX_MISA)
                r = 32'h4000_0104; // rv32 with I and C
            else if (idx == `CSR_IDX_MTVEC)
                r = mtvec;
            else if (idx == `CSR_IDX_MSCRATCH)
                r = mscratch;
            else if (idx == `CSR_IDX_MEPC)
                r = mepc;
            else if (idx == `CSR_IDX_MCAUSE)
                r = mcause;
        end
        return r;
    endfunction

    always @(posedge i_clk)
    begin
        if (i_reset)
        begin
            {mstatus, mtvec, mscratch, mepc, mcause} = '0;
            cyc = '0;
            inst = '0;
            p_op = 2'd0;
            p_read = 1'b0;
            p_ebreak = 1'b0;
        end
        else
        begin
            cyc = cyc + 1;
            if (i_instr_issued)
                inst = inst + 1;
            if (p_op != 2'd0 && p_idx[9:8] == 2'b11)
            begin
                if (p_idx == `CSR_IDX_MTVEC)
                    mtvec = apply_op(p_op, mtvec, p_wdata) & 32'hFFFF_FFFE;
                if (p_idx == `CSR_IDX_MSCRATCH)
                    mscratch = apply_op(p_op, mscratch, p_wdata);
                if (!p_ebreak && p_idx == `CSR_IDX_MSTATUS)
                    mstatus = apply_op(p_op, mstatus, p_wdata) & 32'h0000_0088;
                if (!p_ebreak && p_idx == `CSR_IDX_MEPC)
                    mepc = apply_op(p_op, mepc, p_wdata) & 32'hFFFF_FFFE;
                if (!p_ebreak && p_idx == `CSR_IDX_MCAUSE)
                    mcause = apply_op(p_op, mcause, p_wdata);
            end
            if (p_ebreak)
            begin
                mstatus = {24'd0, mstatus[3], 7'd0}; // mpie gets mie and mie is cleared
                mepc = p_pc;
                mcause = 32'd3;
            end
            p_op = i_masked ? 2'd0 : i_write ? 2'd1 : i_set ? 2'd2 : i_clear ? 2'd3 : 2'd0;
            p_read = i_read && !i_masked;
            p_ebreak = i_ebreak;
        end
        p_idx = i_idx;
        p_wdata = i_imm_sel ? {27'd0, i_imm} : i_reg_data;
        p_pc = {i_pc_next, 1'b0};
        p_kind = i_exp_kind;
        p_exp = i_exp_value;
    end

    initial
    begin
        o_errors = 0;
        o_checks = 0;
    end

    // outputs are settled mid-cycle
    always @(negedge i_clk)
    begin
        if (!i_reset)
        begin
            o_checks = o_checks + 1;
            if (i_rd_strobe !== p_read)
            begin
                $display("mismatch o_read: got %h expected %h", i_rd_strobe, p_read);
                o_errors = o_errors + 1;
            end
            if (p_read && i_data !== model_read(p_idx))
            begin
                $display("mismatch o_data (idx %h): got %h expected %h",
                         p_idx, i_data, model_read(p_idx));
                o_errors = o_errors + 1;
            end
            if (p_read && (p_kind == 2'd1 || p_kind == 2'd3) && i_data !== p_exp)
            begin
                $display("mismatch o_data vs table (idx %h): got %h expected %h",
                         p_idx, i_data, p_exp);
                o_errors = o_errors + 1;
            end
            if (i_csr_to_trap !== i_ebreak)
            begin
                $display("mismatch o_csr_to_trap: got %h expected %h", i_csr_to_trap, i_ebreak);
                o_errors = o_errors + 1;
            end
            if (i_trap_pc !== mtvec[31:1])
            begin
                $display("mismatch o_trap_pc: got %h expected %h", i_trap_pc, mtvec[31:1]);
                o_errors = o_errors + 1;
            end
            if (i_ret_addr !== mepc[31:1])
            begin
                $display("mismatch o_ret_addr: got %h expected %h", i_ret_addr, mepc[31:1]);
                o_errors = o_errors + 1;
            end
        end
    end

endmodule

// ==== csr_unit.sv ====
`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_unit
#(
    parameter bit HAS_COUNTERS = 1'b1
)
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic [31:0]                 i_reg_data,
    input  logic [11:0]                 i_idx,
    input  logic [4:0]                  i_imm,
    input  logic                        i_imm_sel,
    input  logic                        i_write,
    input  logic                        i_set,
    input  logic                        i_clear,
    input  logic                        i_read,
    input  logic                        i_masked,
    input  logic                        i_ebreak,
    input  logic                        i_instr_issued,
    input  logic [`CSR_IADDR_BITS-1:1]  i_pc_next,
    output logic [31:0]                 o_data,
    output logic                        o_read,
    output logic                        o_csr_to_trap,
    output logic [`CSR_IADDR_BITS-1:1]  o_trap_pc,
    output logic [`CSR_IADDR_BITS-1:1]  o_ret_addr
);

    csr_pkg::csr_op_e   op_next;
    logic [31:0]        wdata_next;
    csr_pkg::csr_req_t  req_q;
    csr_pkg::trap_req_t trap_q;
    logic               read_q;

    logic [1:0]  idx_cat;
    logic        machine_sel;
    logic [31:0] rdata_user;
    logic [31:0] rdata_machine;

    // write > set > clear
    always_comb
    begin
        if (i_masked)
        begin
            op_next = csr_pkg::CSR_OP_NONE;
        end
        else if (i_write)
        begin
            op_next = csr_pkg::CSR_OP_WRITE;
        end
        else if (i_set)
        begin
            op_next = csr_pkg::CSR_OP_SET;
        end
        else if (i_clear)
        begin
            op_next = csr_pkg::CSR_OP_CLEAR;
        end
        else
        begin
            op_next = csr_pkg::CSR_OP_NONE;
        end
    end

    assign wdata_next = i_imm_sel ? {27'd0, i_imm} : i_reg_data;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            req_q.op      <= csr_pkg::CSR_OP_NONE;
            read_q        <= 1'b0;
            trap_q.ebreak <= 1'b0;
        end
        else
        begin
            req_q.op      <= op_next;
            read_q        <= i_read && !i_masked;
            trap_q.ebreak <= i_ebreak;
        end
        req_q.idx   <= i_idx;
        req_q.wdata <= wdata_next;
        trap_q.pc   <= i_pc_next;
    end

    assign idx_cat     = req_q.idx[9:8];
    assign machine_sel = (idx_cat == 2'b11);

    generate
        if (HAS_COUNTERS)
        begin : g_counters
            csr_counters u_counters
            (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_idx          (req_q.idx[7:0]),
                .i_instr_issued (i_instr_issued),
                .o_data         (rdata_user)
            );
        end
        else
        begin : g_no_counters
            assign rdata_user = '0;
        end
    endgenerate

    csr_machine u_machine
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_sel      (machine_sel),
        .i_req      (req_q),
        .i_trap     (trap_q),
        .o_data     (rdata_machine),
        .o_trap_pc  (o_trap_pc),
        .o_ret_addr (o_ret_addr)
    );

    always_comb
    begin
        case (idx_cat)
            2'b00:
            begin
                o_data = rdata_user;
            end
            2'b11:
            begin
                o_data = rdata_machine;
            end
            default:
            begin
                o_data = '0; // supervisor, hypervisor
            end
        endcase
    end

    assign o_read        = read_q;
    assign o_csr_to_trap = i_ebreak; // same-cycle trap request

endmodule

// ==== csr_machine.sv ====
`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_machine
#(
    parameter bit HAS_COMPRESSED = 1'b1
)
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_sel,
    input  csr_pkg::csr_req_t           i_req,
    input  csr_pkg::trap_req_t          i_trap,
    output logic [31:0]                 o_data,
    output logic [`CSR_IADDR_BITS-1:1]  o_trap_pc,
    output logic [`CSR_IADDR_BITS-1:1]  o_ret_addr
);

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    localparam logic [31:0] MSTATUS_WMASK = (32'd1 << MSTATUS_MIE) | (32'd1 << MSTATUS_MPIE);

    // without C, addresses are 4-byte aligned
    localparam logic [31:0] PC_MASK = HAS_COMPRESSED ? 32'hFFFF_FFFE : 32'hFFFF_FFFC;

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;

    logic        wr_en;
    logic [31:0] trap_pc_ext;

    function automatic logic [31:0] rmw
    (
        input csr_pkg::csr_op_e op,
        input logic [31:0]      old_value,
        input logic [31:0]      wdata
    );
        logic [31:0] result;
        case (op)
            csr_pkg::CSR_OP_WRITE:
            begin
                result = wdata;
            end
            csr_pkg::CSR_OP_SET:
            begin
                result = old_value | wdata;
            end
            csr_pkg::CSR_OP_CLEAR:
            begin
                result = old_value & ~wdata;
            end
            default:
            begin
                result = old_value;
            end
        endcase
        return result;
    endfunction

    assign wr_en       = i_sel && (i_req.op != csr_pkg::CSR_OP_NONE);
    assign trap_pc_ext = 32'({i_trap.pc, 1'b0});

    // trap capture wins over a csr write to the same register
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            mstatus <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end
        else if (i_trap.ebreak)
        begin
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE]; // push ie stack
            mstatus[MSTATUS_MIE]  <= 1'b0;
            mepc                  <= trap_pc_ext & PC_MASK;
            mcause                <= `CSR_CAUSE_BREAKPOINT;
        end
        else if (wr_en)
        begin
            case (i_req.idx)
                `CSR_IDX_MSTATUS:
                begin
                    mstatus <= rmw(i_req.op, mstatus, i_req.wdata) & MSTATUS_WMASK;
                end
                `CSR_IDX_MEPC:
                begin
                    mepc <= rmw(i_req.op, mepc, i_req.wdata) & PC_MASK;
                end
                `CSR_IDX_MCAUSE:
                begin
                    mcause <= rmw(i_req.op, mcause, i_req.wdata);
                end
                default:
                begin
                    mstatus <= mstatus;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            mtvec    <= '0;
            mscratch <= '0;
        end
        else if (wr_en)
        begin
            if (i_req.idx == `CSR_IDX_MTVEC)
            begin
                mtvec <= rmw(i_req.op, mtvec, i_req.wdata) & PC_MASK; // direct mode only
            end
            if (i_req.idx == `CSR_IDX_MSCRATCH)
            begin
                mscratch <= rmw(i_req.op, mscratch, i_req.wdata);
            end
        end
    end

    always_comb
    begin
        case (i_req.idx)
            `CSR_IDX_MSTATUS:
            begin
                o_data = mstatus;
            end
            `CSR_IDX_MISA:
            begin
                o_data = `CSR_MISA_VALUE; // writes ignored
            end
            `CSR_IDX_MTVEC:
            begin
                o_data = mtvec;
            end
            `CSR_IDX_MSCRATCH:
            begin
                o_data = mscratch;
            end
            `CSR_IDX_MEPC:
            begin
                o_data = mepc;
            end
            `CSR_IDX_MCAUSE:
            begin
                o_data = mcause;
            end
            default:
            begin
                o_data = '0;
            end
        endcase
    end

    assign o_trap_pc  = mtvec[`CSR_IADDR_BITS-1:1];
    assign o_ret_addr = mepc[`CSR_IADDR_BITS-1:1]; // for a later mret

endmodule

// ==== csr_counters.sv ====
`timescale 1ns/1ps

`include "csr_defines.svh"

module csr_counters
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic [7:0]  i_idx,
    input  logic        i_instr_issued,
    output logic [31:0] o_data
);

    // only the low byte reaches this bank
    localparam logic [11:0] IDX_CYCLE    = `CSR_IDX_CYCLE;
    localparam logic [11:0] IDX_INSTRET  = `CSR_IDX_INSTRET;
    localparam logic [11:0] IDX_CYCLEH   = `CSR_IDX_CYCLEH;
    localparam logic [11:0] IDX_INSTRETH = `CSR_IDX_INSTRETH;

    logic [63:0] cycle_cnt;
    logic [63:0] instret_cnt;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            cycle_cnt <= '0;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 64'd1; // free running
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            instret_cnt <= '0;
        end
        else if (i_instr_issued)
        begin
            instret_cnt <= instret_cnt + 64'd1;
        end
    end

    always_comb
    begin
        case (i_idx)
            IDX_CYCLE[7:0]:
            begin
                o_data = cycle_cnt[31:0];
            end
            IDX_INSTRET[7:0]:
            begin
                o_data = instret_cnt[31:0];
            end
            IDX_CYCLEH[7:0]:
            begin
                o_data = cycle_cnt[63:32];
            end
            IDX_INSTRETH[7:0]:
            begin
                o_data = instret_cnt[63:32];
            end
            default:
            begin
                o_data = '0; // hpm and unknown
            end
        endcase
    end

endmodule

// ==== csr_pkg.sv ====
`include "csr_defines.svh"

package csr_pkg;

    // operation carried by a registered csr request
    typedef enum logic [1:0]
    {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    // request as seen by the banks, one cycle after the strobe
    typedef struct packed
    {
        csr_op_e     op;
        logic [11:0] idx;
        logic [31:0] wdata; // already resolved imm vs register
    } csr_req_t;

    // trap entry information registered with the request
    typedef struct packed
    {
        logic                        ebreak;
        logic [`CSR_IADDR_BITS-1:1]  pc; // address of the next instr
    } trap_req_t;

endpackage

// ==== csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// width of an instruction address whose bit 0 is never stored
`define CSR_IADDR_BITS 32

// machine level indices
`define CSR_IDX_MSTATUS  12'h300
`define CSR_IDX_MISA     12'h301
`define CSR_IDX_MTVEC    12'h305
`define CSR_IDX_MSCRATCH 12'h340
`define CSR_IDX_MEPC     12'h341
`define CSR_IDX_MCAUSE   12'h342

// user level read-only counters
`define CSR_IDX_CYCLE    12'hC00
`define CSR_IDX_INSTRET  12'hC02
`define CSR_IDX_CYCLEH   12'hC80
`define CSR_IDX_INSTRETH 12'hC82

`define CSR_CAUSE_BREAKPOINT 32'd3

// MXL=1 for rv32 with extensions I and C
`define CSR_MISA_VALUE 32'h4000_0104

`endif
